/* hw/fe_config.svh */
//==========================================================
// fetch front end configuration macros
// address widths, ITLB size, cache geometry, attribute rules
//==========================================================
`ifndef FE_CONFIG_SVH
`define FE_CONFIG_SVH

`define FE_VADDR_WIDTH 32
`define FE_PTAG_WIDTH 20
`define FE_ITLB_ENTRIES 4
`define FE_ICACHE_SETS 16
`define FE_LINE_WORDS 4
`define FE_INSTR_WIDTH 32

// pages with the top tag bit set bypass the cache
`define FE_UNCACHED_PTAG_MSB(ptag) (ptag[`FE_PTAG_WIDTH-1])
// the top quarter of the physical space has nothing behind it
`define FE_FAULT_PTAG_TOP(ptag) (ptag[`FE_PTAG_WIDTH-1 -: 2] == 2'b11)

`endif

/* hw/fe_pkg.sv */
//==========================================================
// fetch front end types
// command opcodes, ITLB entry layout, cache FSM states
//==========================================================
`include "fe_config.svh"

package fe_pkg;

  typedef enum logic [1:0] {
    e_op_fetch        = 2'd0,
    e_op_tlb_fill     = 2'd1,
    e_op_tlb_fence    = 2'd2,
    e_op_icache_fence = 2'd3
  } fe_op_e;

  // a translation result, x is the execute permission
  typedef struct packed {
    logic [`FE_PTAG_WIDTH-1:0] ptag;
    logic                      x;
  } fe_tlb_entry_s;

  typedef enum logic [2:0] {
    e_ic_idle,
    e_ic_lookup,
    e_ic_refill,
    e_ic_uncached,
    e_ic_respond
  } fe_icache_state_e;

endpackage

/* hw/fe_itlb_if.sv */
//==========================================================
// fetch controller to ITLB interface
//==========================================================
`timescale 1ns/10ps
`include "fe_config.svh"

interface fe_itlb_if;
  import fe_pkg::*;

  logic                      lookup_v;
  logic                      fill_v;
  logic                      flush_v;
  logic [`FE_PTAG_WIDTH-1:0] vtag;
  fe_tlb_entry_s             fill_entry;
  logic                      hit_v;
  logic                      miss_v;
  fe_tlb_entry_s             hit_entry;

  modport ctrl (output lookup_v, fill_v, flush_v, vtag, fill_entry,
                input  hit_v, miss_v, hit_entry);
  modport tlb  (input  lookup_v, fill_v, flush_v, vtag, fill_entry,
                output hit_v, miss_v, hit_entry);
endinterface

/* hw/fe_icache_if.sv */
//==========================================================
// fetch controller to instruction cache interface
//==========================================================
`timescale 1ns/10ps
`include "fe_config.svh"

interface fe_icache_if;
  import fe_pkg::*;

  logic                       req_v;
  fe_op_e                     req_op;
  logic [`FE_VADDR_WIDTH-1:0] vaddr;
  // second cycle of a fetch
  logic [`FE_PTAG_WIDTH-1:0]  ptag;
  logic                       ptag_v;
  logic                       uncached;
  logic                       poison;
  logic [`FE_INSTR_WIDTH-1:0] data;
  logic                       data_v;
  logic                       miss_done;
  logic                       busy;

  modport ctrl  (output req_v, req_op, vaddr, ptag, ptag_v, uncached, poison,
                 input  data, data_v, miss_done, busy);
  modport cache (input  req_v, req_op, vaddr, ptag, ptag_v, uncached, poison,
                 output data, data_v, miss_done, busy);
endinterface

/* hw/fe_itlb.sv */
//==========================================================
// fully associative ITLB
// registered lookup, round-robin fill, flush
//==========================================================
`timescale 1ns/10ps
`include "fe_config.svh"

module fe_itlb (
  input logic    clk_i,
  input logic    reset_i,
  fe_itlb_if.tlb tlb
);
  import fe_pkg::*;

  localparam int ptr_width_lp = $clog2(`FE_ITLB_ENTRIES);

  logic [`FE_ITLB_ENTRIES-1:0] valid_r;
  logic [`FE_PTAG_WIDTH-1:0]   vtag_r [`FE_ITLB_ENTRIES];
  fe_tlb_entry_s               entry_r [`FE_ITLB_ENTRIES];
  logic [ptr_width_lp-1:0]     rr_ptr_r;
  logic [`FE_ITLB_ENTRIES-1:0] match;
  logic [ptr_width_lp-1:0]     match_idx;
  logic [ptr_width_lp-1:0]     fill_idx;
  logic                        hit_v_r;
  logic                        miss_v_r;
  fe_tlb_entry_s               hit_entry_r;

  always_comb begin
    match_idx = '0;
    for (int i = 0; i < `FE_ITLB_ENTRIES; i++) begin
      match[i] = valid_r[i] & (vtag_r[i] == tlb.vtag);
      if (match[i]) begin
        match_idx = ptr_width_lp'(i);
      end
    end
  end

  // a refill of a present page reuses its slot
  assign fill_idx = (|match) ? match_idx : rr_ptr_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_r  <= '0;
      rr_ptr_r <= '0;
      hit_v_r  <= 1'b0;
      miss_v_r <= 1'b0;
    end else begin
      hit_v_r  <= tlb.lookup_v & (|match);
      miss_v_r <= tlb.lookup_v & ~(|match);
      if (tlb.flush_v) begin
        valid_r <= '0;
      end else if (tlb.fill_v) begin
        valid_r[fill_idx] <= 1'b1;
        if (!(|match)) begin
          rr_ptr_r <= rr_ptr_r + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (tlb.lookup_v) begin
      hit_entry_r <= entry_r[match_idx];
    end
    if (tlb.fill_v) begin
      vtag_r[fill_idx]  <= tlb.vtag;
      entry_r[fill_idx] <= tlb.fill_entry;
    end
  end

  assign tlb.hit_v     = hit_v_r;
  assign tlb.miss_v    = miss_v_r;
  assign tlb.hit_entry = hit_entry_r;

  // fills never leave two slots with the same tag
  a_hit_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
    tlb.lookup_v |-> $onehot0(match));

endmodule

/* hw/fe_icache.sv */
//==========================================================
// direct-mapped, physically tagged instruction cache
// refill and uncached read FSM on a word-wide memory port
//==========================================================
`timescale 1ns/10ps
`include "fe_config.svh"

module fe_icache (
  input  logic                         clk_i,
  input  logic                         reset_i,
  fe_icache_if.cache                   cache,
  output logic                         mem_req_v_o,
  output logic [`FE_VADDR_WIDTH-3:0]   mem_req_addr_o,
  input  logic                         mem_resp_v_i,
  input  logic [`FE_INSTR_WIDTH-1:0]   mem_resp_data_i
);
  import fe_pkg::*;

  localparam int index_width_lp  = $clog2(`FE_ICACHE_SETS);
  localparam int offset_width_lp = $clog2(`FE_LINE_WORDS);
  localparam int page_bits_lp    = `FE_VADDR_WIDTH - `FE_PTAG_WIDTH;
  localparam int line_lsb_lp     = index_width_lp + offset_width_lp + 2;
  localparam int tag_width_lp    = `FE_PTAG_WIDTH + page_bits_lp - line_lsb_lp;

  fe_icache_state_e             state_r;
  fe_icache_state_e             state_n;
  logic [`FE_ICACHE_SETS-1:0]   valid_r;
  logic [tag_width_lp-1:0]      tag_mem [`FE_ICACHE_SETS];
  logic [`FE_INSTR_WIDTH-1:0]   data_mem [`FE_ICACHE_SETS*`FE_LINE_WORDS];
  logic [`FE_VADDR_WIDTH-1:0]   vaddr_r;
  logic [`FE_PTAG_WIDTH-1:0]    ptag_r;
  logic                         uncached_r;
  logic [offset_width_lp-1:0]   cnt_r;
  logic                         wait_r;
  logic [`FE_INSTR_WIDTH-1:0]   word_r;
  logic [index_width_lp-1:0]    index;
  logic [offset_width_lp-1:0]   offset;
  logic [tag_width_lp-1:0]      lookup_tag;
  logic                         hit;
  logic                         lookup_ok;
  logic                         last_resp;

  assign index      = vaddr_r[offset_width_lp+2 +: index_width_lp];
  assign offset     = vaddr_r[2 +: offset_width_lp];
  assign lookup_tag = {cache.ptag, vaddr_r[page_bits_lp-1:line_lsb_lp]};
  assign hit        = valid_r[index] & (tag_mem[index] == lookup_tag);
  assign lookup_ok  = (state_r == e_ic_lookup) & cache.ptag_v & ~cache.poison;
  assign last_resp  = mem_resp_v_i & ((state_r == e_ic_uncached) |
                      ((state_r == e_ic_refill) & (cnt_r == '1)));

  //==========================================================
  // state machine
  //==========================================================
  always_comb begin
    state_n = state_r;
    unique case (state_r)
      e_ic_idle: begin
        if (cache.req_v && cache.req_op == e_op_fetch) begin
          state_n = e_ic_lookup;
        end
      end
      e_ic_lookup: begin
        if (!lookup_ok) state_n = e_ic_idle;
        else if (cache.uncached) state_n = e_ic_uncached;
        else if (hit) state_n = e_ic_idle;
        else state_n = e_ic_refill;
      end
      e_ic_refill,
      e_ic_uncached: begin
        if (last_resp) state_n = e_ic_respond;
      end
      default: state_n = e_ic_idle;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= e_ic_idle;
      wait_r  <= 1'b0;
      cnt_r   <= '0;
      valid_r <= '0;
    end else begin
      state_r <= state_n;
      if (mem_req_v_o) wait_r <= 1'b1;
      else if (mem_resp_v_i) wait_r <= 1'b0;
      if (state_r == e_ic_lookup) cnt_r <= '0;
      else if (state_r == e_ic_refill && mem_resp_v_i) cnt_r <= cnt_r + 1'b1;
      if (state_r == e_ic_idle && cache.req_v && cache.req_op == e_op_icache_fence) begin
        valid_r <= '0;
      end else if (state_r == e_ic_respond && !uncached_r) begin
        valid_r[index] <= 1'b1;
      end
    end
  end

  //==========================================================
  // arrays and request context
  //==========================================================
  always_ff @(posedge clk_i) begin
    if (state_r == e_ic_idle && cache.req_v) vaddr_r <= cache.vaddr;
    if (state_r == e_ic_lookup) begin
      ptag_r     <= cache.ptag;
      uncached_r <= cache.uncached;
    end
    if (state_r == e_ic_refill && mem_resp_v_i) begin
      data_mem[{index, cnt_r}] <= mem_resp_data_i;
      if (cnt_r == offset) word_r <= mem_resp_data_i;
    end
    if (state_r == e_ic_respond && !uncached_r) begin
      tag_mem[index] <= {ptag_r, vaddr_r[page_bits_lp-1:line_lsb_lp]};
    end
  end

  // words go out in address order, one at a time
  assign mem_req_v_o    = ((state_r == e_ic_refill) | (state_r == e_ic_uncached)) & ~wait_r;
  assign mem_req_addr_o = (state_r == e_ic_uncached) ? {ptag_r, vaddr_r[page_bits_lp-1:2]}
                        : {ptag_r, vaddr_r[page_bits_lp-1:offset_width_lp+2], cnt_r};

  always_comb begin
    if (state_r == e_ic_lookup) cache.data = data_mem[{index, offset}];
    else if (state_r == e_ic_uncached || cnt_r == offset) cache.data = mem_resp_data_i;
    else cache.data = word_r;
  end

  assign cache.data_v    = (lookup_ok & ~cache.uncached & hit) | last_resp;
  assign cache.miss_done = last_resp;
  assign cache.busy      = (state_r != e_ic_idle);

  a_one_outstanding: assert property (@(posedge clk_i) disable iff (reset_i)
    mem_req_v_o |=> (!mem_req_v_o until_with mem_resp_v_i));

endmodule

/* hw/fe_fetch_ctrl.sv */
//==========================================================
// fetch controller
// command decode, translation select, attribute and fault
// checks, response stage and busy status
//==========================================================
`timescale 1ns/10ps
`include "fe_config.svh"

module fe_fetch_ctrl (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic                       cmd_v_i,
  input  fe_pkg::fe_op_e             cmd_op_i,
  input  logic [`FE_VADDR_WIDTH-1:0] cmd_vaddr_i,
  input  fe_pkg::fe_tlb_entry_s      cmd_entry_i,
  input  logic                       trans_en_i,
  output logic                       busy_o,
  output logic                       resp_v_o,
  output logic [`FE_INSTR_WIDTH-1:0] resp_instr_o,
  output logic                       resp_itlb_miss_o,
  output logic                       resp_access_fault_o,
  output logic                       resp_page_fault_o,
  fe_itlb_if.ctrl                    itlb,
  fe_icache_if.ctrl                  icache
);
  import fe_pkg::*;

  logic                       fetch_v;
  logic                       fetch_v_r;
  logic                       trans_r;
  logic [`FE_PTAG_WIDTH-1:0]  vtag_r;
  logic [`FE_PTAG_WIDTH-1:0]  ptag_sel;
  logic                       ptag_v;
  logic                       exec_ok;
  logic                       itlb_miss;
  logic                       page_fault;
  logic                       access_fault;
  logic                       any_flag;
  logic                       resp_v_d;
  logic                       mem_wait_r;
  logic                       fetch_act_r;
  logic                       side_r;
  logic                       resp_v_r;
  logic                       itlb_miss_r;
  logic                       page_fault_r;
  logic                       access_fault_r;
  logic [`FE_INSTR_WIDTH-1:0] instr_r;

  //==========================================================
  // stage one, command decode
  //==========================================================
  assign fetch_v         = cmd_v_i & (cmd_op_i == e_op_fetch);
  assign itlb.lookup_v   = fetch_v & trans_en_i;
  assign itlb.fill_v     = cmd_v_i & (cmd_op_i == e_op_tlb_fill);
  assign itlb.flush_v    = cmd_v_i & (cmd_op_i == e_op_tlb_fence);
  assign itlb.vtag       = cmd_vaddr_i[`FE_VADDR_WIDTH-1 -: `FE_PTAG_WIDTH];
  assign itlb.fill_entry = cmd_entry_i;
  assign icache.req_v    = fetch_v | (cmd_v_i & (cmd_op_i == e_op_icache_fence));
  assign icache.req_op   = cmd_op_i;
  assign icache.vaddr    = cmd_vaddr_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      fetch_v_r <= 1'b0;
      trans_r   <= 1'b0;
    end else begin
      fetch_v_r <= fetch_v;
      if (fetch_v) trans_r <= trans_en_i;
    end
  end

  // the untranslated page tag for the passthrough case
  always_ff @(posedge clk_i) begin
    if (fetch_v) vtag_r <= cmd_vaddr_i[`FE_VADDR_WIDTH-1 -: `FE_PTAG_WIDTH];
  end

  //==========================================================
  // stage two, translation and checks
  //==========================================================
  assign ptag_sel     = trans_r ? itlb.hit_entry.ptag : vtag_r;
  assign ptag_v       = fetch_v_r & (~trans_r | itlb.hit_v);
  assign exec_ok      = ~trans_r | itlb.hit_entry.x;
  // priority is miss, then page fault, then access fault
  assign itlb_miss    = fetch_v_r & trans_r & itlb.miss_v;
  assign page_fault   = ptag_v & ~exec_ok;
  assign access_fault = ptag_v & exec_ok & `FE_FAULT_PTAG_TOP(ptag_sel);
  assign any_flag     = itlb_miss | page_fault | access_fault;

  assign icache.ptag     = ptag_sel;
  assign icache.ptag_v   = ptag_v;
  assign icache.uncached = `FE_UNCACHED_PTAG_MSB(ptag_sel);
  assign icache.poison   = any_flag;

  assign resp_v_d = (fetch_v_r & (any_flag | icache.data_v)) | (mem_wait_r & icache.miss_done);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      mem_wait_r     <= 1'b0;
      fetch_act_r    <= 1'b0;
      side_r         <= 1'b0;
      resp_v_r       <= 1'b0;
      itlb_miss_r    <= 1'b0;
      page_fault_r   <= 1'b0;
      access_fault_r <= 1'b0;
    end else begin
      if (fetch_v_r && !any_flag && !icache.data_v) mem_wait_r <= 1'b1;
      else if (icache.miss_done) mem_wait_r <= 1'b0;
      if (fetch_v) fetch_act_r <= 1'b1;
      else if (resp_v_r) fetch_act_r <= 1'b0;
      side_r         <= cmd_v_i & ~fetch_v;
      resp_v_r       <= resp_v_d;
      itlb_miss_r    <= itlb_miss;
      page_fault_r   <= page_fault;
      access_fault_r <= access_fault;
    end
  end

  always_ff @(posedge clk_i) begin
    if (icache.data_v) instr_r <= icache.data;
  end

  assign busy_o              = fetch_act_r | side_r | icache.busy;
  assign resp_v_o            = resp_v_r;
  assign resp_instr_o        = instr_r;
  assign resp_itlb_miss_o    = itlb_miss_r;
  assign resp_page_fault_o   = page_fault_r;
  assign resp_access_fault_o = access_fault_r;

  a_no_cmd_when_busy: assert property (@(posedge clk_i) disable iff (reset_i)
    cmd_v_i |-> !busy_o);

endmodule

/* hw/fe_top.sv */
//==========================================================
// instruction fetch front end top level
// fetch controller, ITLB and instruction cache
//==========================================================
`timescale 1ns/10ps
`include "fe_config.svh"

module fe_top (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic                       cmd_v_i,
  input  fe_pkg::fe_op_e             cmd_op_i,
  input  logic [`FE_VADDR_WIDTH-1:0] cmd_vaddr_i,
  input  fe_pkg::fe_tlb_entry_s      cmd_entry_i,
  input  logic                       trans_en_i,
  output logic                       busy_o,
  output logic                       resp_v_o,
  output logic [`FE_INSTR_WIDTH-1:0] resp_instr_o,
  output logic                       resp_itlb_miss_o,
  output logic                       resp_access_fault_o,
  output logic                       resp_page_fault_o,
  output logic                       mem_req_v_o,
  output logic [`FE_VADDR_WIDTH-3:0] mem_req_addr_o,
  input  logic                       mem_resp_v_i,
  input  logic [`FE_INSTR_WIDTH-1:0] mem_resp_data_i
);

  fe_itlb_if   itlb_if ();
  fe_icache_if icache_if ();

  fe_fetch_ctrl i_ctrl (
    .clk_i               (clk_i),
    .reset_i             (reset_i),
    .cmd_v_i             (cmd_v_i),
    .cmd_op_i            (cmd_op_i),
    .cmd_vaddr_i         (cmd_vaddr_i),
    .cmd_entry_i         (cmd_entry_i),
    .trans_en_i          (trans_en_i),
    .busy_o              (busy_o),
    .resp_v_o            (resp_v_o),
    .resp_instr_o        (resp_instr_o),
    .resp_itlb_miss_o    (resp_itlb_miss_o),
    .resp_access_fault_o (resp_access_fault_o),
    .resp_page_fault_o   (resp_page_fault_o),
    .itlb                (itlb_if.ctrl),
    .icache              (icache_if.ctrl)
  );

  fe_itlb i_itlb (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .tlb     (itlb_if.tlb)
  );

  fe_icache i_icache (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .cache           (icache_if.cache),
    .mem_req_v_o     (mem_req_v_o),
    .mem_req_addr_o  (mem_req_addr_o),
    .mem_resp_v_i    (mem_resp_v_i),
    .mem_resp_data_i (mem_resp_data_i)
  );

endmodule

/* verification/fe_tb.sv */
//==========================================================
// random-stimulus testbench for the fetch front end
// memory model, ITLB and cache reference model, checks
//==========================================================
`timescale 1ns/10ps
`include "fe_config.svh"

module fe_tb;
  import fe_pkg::*;

  localparam int num_cmds_lp    = 400;
  localparam int warmup_cmds_lp = 24;
  // a refill with four slow memory reads stays well below 40 cycles
  localparam int cycle_limit_lp = num_cmds_lp * 40;

  logic                       clk_i;
  logic                       reset_i;
  logic                       cmd_v_i;
  fe_op_e                     cmd_op_i;
  logic [`FE_VADDR_WIDTH-1:0] cmd_vaddr_i;
  fe_tlb_entry_s              cmd_entry_i;
  logic                       trans_en_i;
  logic                       busy_o;
  logic                       resp_v_o;
  logic [`FE_INSTR_WIDTH-1:0] resp_instr_o;
  logic                       resp_itlb_miss_o;
  logic                       resp_access_fault_o;
  logic                       resp_page_fault_o;
  logic                       mem_req_v_o;
  logic [`FE_VADDR_WIDTH-3:0] mem_req_addr_o;
  logic                       mem_resp_v_i = 1'b0;
  logic [`FE_INSTR_WIDTH-1:0] mem_resp_data_i = '0;

  integer seed = 32'h1238_4f51;
  integer mem_seed;
  int     errors = 0;
  int     checks = 0;
  int     fetches = 0;
  int     mem_reqs = 0;
  int     cycle_cnt = 0;

  logic                       mem_pending;
  logic [`FE_VADDR_WIDTH-3:0] mem_addr;
  int                         mem_delay;
  logic [`FE_VADDR_WIDTH-3:0] mem_log [$];

  logic                       tlb_valid [`FE_ITLB_ENTRIES];
  logic [`FE_PTAG_WIDTH-1:0]  tlb_vtag  [`FE_ITLB_ENTRIES];
  fe_tlb_entry_s              tlb_entry [`FE_ITLB_ENTRIES];
  int                         tlb_rr;
  logic                       ic_valid  [`FE_ICACHE_SETS];
  logic [23:0]                ic_tag    [`FE_ICACHE_SETS];

  fe_top i_dut (
    .clk_i               (clk_i),
    .reset_i             (reset_i),
    .cmd_v_i             (cmd_v_i),
    .cmd_op_i            (cmd_op_i),
    .cmd_vaddr_i         (cmd_vaddr_i),
    .cmd_entry_i         (cmd_entry_i),
    .trans_en_i          (trans_en_i),
    .busy_o              (busy_o),
    .resp_v_o            (resp_v_o),
    .resp_instr_o        (resp_instr_o),
    .resp_itlb_miss_o    (resp_itlb_miss_o),
    .resp_access_fault_o (resp_access_fault_o),
    .resp_page_fault_o   (resp_page_fault_o),
    .mem_req_v_o         (mem_req_v_o),
    .mem_req_addr_o      (mem_req_addr_o),
    .mem_resp_v_i        (mem_resp_v_i),
    .mem_resp_data_i     (mem_resp_data_i)
  );

  initial clk_i = 1'b0;
  always #10 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt > cycle_limit_lp) begin
      $display("timeout after %0d cycles, the command sequence did not finish", cycle_limit_lp);
      $display("Result: FAILED");
      $finish;
    end
  end

  // every word of memory is a mix of its whole word address
  function automatic logic [31:0] mem_word(input logic [29:0] waddr);
    mem_word = {waddr, 2'b11} ^ {waddr[13:0], waddr[29:12]} ^ 32'h5bd1_e995;
  endfunction

  //==========================================================
  // memory model, one request outstanding, 1 to 4 cycles
  //==========================================================
  always @(posedge clk_i) begin
    mem_resp_v_i <= 1'b0;
    if (reset_i) begin
      mem_pending = 1'b0;
      mem_delay   = 0;
    end else begin
      if (mem_req_v_o) begin
        if (mem_pending) begin
          errors++;
          $display("memory request issued while another one was still outstanding");
        end
        mem_pending = 1'b1;
        mem_addr    = mem_req_addr_o;
        mem_delay   = int'($unsigned($random(mem_seed)) % 4);
        mem_log.push_back(mem_req_addr_o);
        mem_reqs++;
      end
      if (mem_pending) begin
        if (mem_delay == 0) begin
          mem_resp_v_i    <= 1'b1;
          mem_resp_data_i <= mem_word(mem_addr);
          mem_pending = 1'b0;
        end else begin
          mem_delay--;
        end
      end
    end
  end

  function automatic int rand_below(input int n);
    rand_below = int'($unsigned($random(seed)) % n);
  endfunction

  // cached, uncached and non-existent physical pages
  function automatic logic [19:0] pool_ptag(input int i);
    case (i)
      0:       pool_ptag = 20'h00020;
      1:       pool_ptag = 20'h00021;
      2:       pool_ptag = 20'h00345;
      3:       pool_ptag = 20'h7ff00;
      4:       pool_ptag = 20'h80010;
      5:       pool_ptag = 20'ha1234;
      6:       pool_ptag = 20'hc0000;
      default: pool_ptag = 20'hfffff;
    endcase
  endfunction

  function automatic logic [19:0] pool_vtag(input int i);
    pool_vtag = 20'h00100 + 20'(i);
  endfunction

  // few lines and two tags per index, so hits and conflicts both happen
  function automatic logic [11:0] pick_offset();
    logic       hi;
    logic [1:0] idx;
    logic [1:0] word;
    hi   = 1'(rand_below(2));
    idx  = 2'(rand_below(4));
    word = 2'(rand_below(4));
    pick_offset = {3'b000, hi, 2'b00, idx, word, 2'b00};
  endfunction

  task automatic check_hex(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch %s: got %h, expected %h", name, got, exp);
    end
  endtask

  function automatic void model_reset();
    for (int i = 0; i < `FE_ITLB_ENTRIES; i++) tlb_valid[i] = 1'b0;
    for (int i = 0; i < `FE_ICACHE_SETS; i++) ic_valid[i] = 1'b0;
    tlb_rr = 0;
  endfunction

  task automatic drive_cmd(input fe_op_e op, input logic [31:0] vaddr,
                           input fe_tlb_entry_s entry, input logic trans);
    cmd_v_i     <= 1'b1;
    cmd_op_i    <= op;
    cmd_vaddr_i <= vaddr;
    cmd_entry_i <= entry;
    trans_en_i  <= trans;
    @(posedge clk_i);
    cmd_v_i <= 1'b0;
  endtask

  //==========================================================
  // fills and fences, busy for one cycle and no response
  //==========================================================
  task automatic run_side_cmd(input fe_op_e op, input logic [31:0] vaddr,
                              input fe_tlb_entry_s entry, input logic trans);
    int slot;
    slot = -1;
    mem_log.delete();
    case (op)
      e_op_tlb_fill: begin
        for (int i = 0; i < `FE_ITLB_ENTRIES; i++) begin
          if (tlb_valid[i] && tlb_vtag[i] == vaddr[31:12]) slot = i;
        end
        if (slot < 0) begin
          slot   = tlb_rr;
          tlb_rr = (tlb_rr + 1) % `FE_ITLB_ENTRIES;
        end
        tlb_valid[slot] = 1'b1;
        tlb_vtag[slot]  = vaddr[31:12];
        tlb_entry[slot] = entry;
      end
      e_op_tlb_fence: begin
        for (int i = 0; i < `FE_ITLB_ENTRIES; i++) tlb_valid[i] = 1'b0;
      end
      default: begin
        for (int i = 0; i < `FE_ICACHE_SETS; i++) ic_valid[i] = 1'b0;
      end
    endcase
    drive_cmd(op, vaddr, entry, trans);
    @(posedge clk_i);
    if (!busy_o) begin
      errors++;
      $display("busy_o did not rise after a %s command", op.name());
    end
    check_hex("resp_v_o", 32'(resp_v_o), 32'h0);
    @(posedge clk_i);
    if (busy_o) begin
      errors++;
      $display("busy_o stayed high longer than one cycle after a %s command", op.name());
    end
    check_hex("resp_v_o", 32'(resp_v_o), 32'h0);
    check_hex("mem_req_v_o count", 32'(mem_log.size()), 32'h0);
  endtask

  //==========================================================
  // fetch, predicted by the reference model and then checked
  //==========================================================
  task automatic run_fetch(input logic [31:0] vaddr, input logic trans);
    logic [19:0] ptag;
    logic        x;
    logic        tlb_hit;
    logic        exp_miss;
    logic        exp_pf;
    logic        exp_af;
    logic        flagged;
    logic        uncached;
    logic        fast;
    logic [31:0] paddr;
    logic [31:0] exp_instr;
    logic [31:0] exp_addr;
    logic [3:0]  idx;
    int          exp_reqs;
    int          lat;
    logic        done;
    logic        got_miss;
    logic        got_pf;
    logic        got_af;
    logic [31:0] got_instr;
    tlb_hit = 1'b0;
    ptag    = vaddr[31:12];
    x       = 1'b1;
    if (trans) begin
      for (int i = 0; i < `FE_ITLB_ENTRIES; i++) begin
        if (tlb_valid[i] && tlb_vtag[i] == vaddr[31:12]) begin
          tlb_hit = 1'b1;
          ptag    = tlb_entry[i].ptag;
          x       = tlb_entry[i].x;
        end
      end
    end
    exp_miss  = trans & ~tlb_hit;
    exp_pf    = ~exp_miss & ~x;
    exp_af    = ~exp_miss & x & (ptag[19:18] == 2'b11);
    flagged   = exp_miss | exp_pf | exp_af;
    paddr     = {ptag, vaddr[11:0]};
    uncached  = ptag[19];
    idx       = paddr[7:4];
    exp_instr = mem_word(paddr[31:2]);
    exp_reqs  = 0;
    fast      = 1'b1;
    if (!flagged && uncached) begin
      exp_reqs = 1;
      fast     = 1'b0;
    end else if (!flagged && !(ic_valid[idx] && ic_tag[idx] == paddr[31:8])) begin
      exp_reqs     = 4;
      fast         = 1'b0;
      ic_valid[idx] = 1'b1;
      ic_tag[idx]   = paddr[31:8];
    end

    mem_log.delete();
    fetches++;
    drive_cmd(e_op_fetch, vaddr, '0, trans);
    lat  = 0;
    done = 1'b0;
    while (!done) begin
      @(posedge clk_i);
      lat++;
      if (resp_v_o) begin
        done      = 1'b1;
        got_miss  = resp_itlb_miss_o;
        got_pf    = resp_page_fault_o;
        got_af    = resp_access_fault_o;
        got_instr = resp_instr_o;
      end
      if (!busy_o) begin
        errors++;
        $display("busy_o was low while the fetch at %h was still open", vaddr);
        done = 1'b1;
      end
    end
    @(posedge clk_i);
    if (busy_o) begin
      errors++;
      $display("busy_o did not fall the cycle after the response to %h", vaddr);
    end
    check_hex("resp_v_o", 32'(resp_v_o), 32'h0);

    check_hex("resp_itlb_miss_o", 32'(got_miss), 32'(exp_miss));
    check_hex("resp_page_fault_o", 32'(got_pf), 32'(exp_pf));
    check_hex("resp_access_fault_o", 32'(got_af), 32'(exp_af));
    if (!flagged) check_hex("resp_instr_o", got_instr, exp_instr);
    if (fast && lat != 2) begin
      errors++;
      $display("response to %h came %0d cycles after the command instead of 2", vaddr, lat);
    end
    check_hex("mem_req_v_o count", 32'(mem_log.size()), 32'(exp_reqs));
    for (int k = 0; k < mem_log.size() && k < exp_reqs; k++) begin
      exp_addr = uncached ? {2'b00, paddr[31:2]} : {2'b00, paddr[31:4], 2'(k)};
      check_hex("mem_req_addr_o", {2'b00, mem_log[k]}, exp_addr);
    end
  endtask

  initial begin
    int            pick;
    logic          trans_lvl;
    fe_tlb_entry_s entry;
    logic [31:0]   vaddr;
    mem_seed    = $random(seed);
    reset_i     = 1'b1;
    cmd_v_i     = 1'b0;
    cmd_op_i    = e_op_fetch;
    cmd_vaddr_i = '0;
    cmd_entry_i = '0;
    trans_en_i  = 1'b0;
    trans_lvl   = 1'b0;
    model_reset();
    repeat (16) @(posedge clk_i);
    reset_i <= 1'b0;
    @(posedge clk_i);
    check_hex("busy_o", 32'(busy_o), 32'h0);
    check_hex("resp_v_o", 32'(resp_v_o), 32'h0);
    check_hex("mem_req_v_o", 32'(mem_req_v_o), 32'h0);

    // untranslated fetches first, then a random mix with translation on
    for (int i = 0; i < num_cmds_lp; i++) begin
      if (i == warmup_cmds_lp) trans_lvl = 1'b1;
      else if (i > warmup_cmds_lp && rand_below(10) == 0) trans_lvl = ~trans_lvl;
      pick       = (i < warmup_cmds_lp) ? 0 : rand_below(100);
      entry.ptag = pool_ptag(rand_below(8));
      entry.x    = (rand_below(8) != 0);
      if (pick < 60) begin
        if (trans_lvl) vaddr = {pool_vtag(rand_below(6)), pick_offset()};
        else vaddr = {pool_ptag(rand_below(8)), pick_offset()};
        run_fetch(vaddr, trans_lvl);
      end else if (pick < 82) begin
        vaddr = {pool_vtag(rand_below(6)), pick_offset()};
        run_side_cmd(e_op_tlb_fill, vaddr, entry, trans_lvl);
      end else if (pick < 90) begin
        run_side_cmd(e_op_tlb_fence, 32'h0, entry, trans_lvl);
      end else begin
        run_side_cmd(e_op_icache_fence, 32'h0, entry, trans_lvl);
      end
    end

    $display("fetches %0d, memory requests %0d, checks %0d, errors %0d",
             fetches, mem_reqs, checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

/* files.f */
+incdir+hw
hw/fe_pkg.sv
hw/fe_itlb_if.sv
hw/fe_icache_if.sv
hw/fe_itlb.sv
hw/fe_icache.sv
hw/fe_fetch_ctrl.sv
hw/fe_top.sv
verification/fe_tb.sv

/* Bender.yml */
package:
  name: fe_frontend

export_include_dirs:
  - hw

sources:
  - hw/fe_pkg.sv
  - hw/fe_itlb_if.sv
  - hw/fe_icache_if.sv
  - hw/fe_itlb.sv
  - hw/fe_icache.sv
  - hw/fe_fetch_ctrl.sv
  - hw/fe_top.sv
  - target: simulation
    files:
      - verification/fe_tb.sv
